// ==== pe_trace.txt ====
# cmd a b: P addr inst, M addr word, N word flags (bit0 stalled before, bit1 full after)
# B level cycles, S start, E expected neigh_data_out, D wait for eoi; all fields hex
M 0 0007
M 1 fffd
M 2 8000
# pass, sub, mul, max, add, max over data, interim and result
P 0 a0011
P 1 40e13
P 2 68821
P 3 88835
P 4 38201
P 5 81601
P 6 00000
E 00000007
E fffffff6
E 0000001e
E fffffffd
E 00000004
E 00000004
S
D
# neighbor program, starved input and blocked output
P 0 30401
P 1 50601
P 2 00000
E 00000012
E fffffff3
S
B 0 5
N 00000009 1
B 1 14
B 0 8
N 00000005 1
D
# fill the fifo, then two identical runs drain it
N 00000002 0
N 0000000b 0
N 00000002 0
N 0000000b 2
E 00000004
E 00000007
S
D
E 00000004
E 00000007
S
D

// ==== all.f ====
+incdir+.
pe_pkg.sv
instruction_memory.sv
data_memory.sv
interim_buffer.sv
neigh_fifo.sv
pe_compute.sv
pe_control.sv
pe_top.sv
tb_pe.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_pe -f all.f -o tb_pe_sim
./obj_dir/tb_pe_sim | tee sim.log

if grep -qx "Simulation PASSED" sim.log; then
	echo "run.sh: test passed"
	exit 0
fi
echo "run.sh: test failed"
exit 1

// ==== tb_pe.sv ====
`timescale 1ns/100ps

module tb_pe import pe_pkg::*; ();

	logic clk;
	logic rstn;
	logic start;
	logic prog_wrt;
	inst_addr_t prog_addr;
	inst_t prog_data;
	logic mem_wrt;
	mem_addr_t mem_addr;
	mem_word_t mem_data;
	data_t neigh_data_in;
	logic neigh_data_in_v;
	logic neigh_full_in;
	logic neigh_full;
	data_t neigh_data_out;
	logic neigh_data_out_v;
	logic pe_stall;
	logic eoi;

	data_t expect_q[$];
	int value_errs = 0;
	int proto_errs = 0;
	int eoi_count = 0;
	int start_count = 0;
	int line_count = 0;

	pe_top u_pe_top (
		.clk(clk), .rstn(rstn), .start(start),
		.prog_wrt(prog_wrt), .prog_addr(prog_addr), .prog_data(prog_data),
		.mem_wrt(mem_wrt), .mem_addr(mem_addr), .mem_data(mem_data),
		.neigh_data_in(neigh_data_in), .neigh_data_in_v(neigh_data_in_v),
		.neigh_full_in(neigh_full_in), .neigh_full(neigh_full),
		.neigh_data_out(neigh_data_out), .neigh_data_out_v(neigh_data_out_v),
		.pe_stall(pe_stall), .eoi(eoi)
	);

	always #50 clk = ~clk;

	//----------------------------------------
	// stimulus tasks, entered and left on a falling edge
	//----------------------------------------
	task automatic load_prog(input inst_addr_t addr, input inst_t word);
		prog_wrt = 1'b1;
		prog_addr = addr;
		prog_data = word;
		@(negedge clk);
		prog_wrt = 1'b0;
	endtask

	task automatic load_data(input mem_addr_t addr, input mem_word_t word);
		mem_wrt = 1'b1;
		mem_addr = addr;
		mem_data = word;
		@(negedge clk);
		mem_wrt = 1'b0;
	endtask

	// flags: bit0 expected pe_stall before the push, bit1 expected neigh_full after
	task automatic push_neigh(input data_t word, input logic [1:0] flags);
		if (pe_stall !== flags[0]) begin
			value_errs++;
			$display("** Error pe_stall expected %h got %h at %0t", flags[0], pe_stall, $time);
		end
		neigh_data_in = word;
		neigh_data_in_v = 1'b1;
		@(negedge clk);
		neigh_data_in_v = 1'b0;
		if (neigh_full !== flags[1]) begin
			value_errs++;
			$display("** Error neigh_full expected %h got %h at %0t", flags[1], neigh_full, $time);
		end
	endtask

	// a high level is only held where an output is pending
	task automatic hold_full_in(input logic level, input int cycles);
		neigh_full_in = level;
		repeat (cycles) @(negedge clk);
		if (level && !pe_stall) begin
			proto_errs++;
			$display("element not stalled after %0d cycles of output back-pressure", cycles);
		end
	endtask

	task automatic pulse_start();
		start = 1'b1;
		start_count++;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic wait_end();
		wait (eoi_count >= start_count);
		@(negedge clk);
	endtask

	//----------------------------------------
	// output monitor
	//----------------------------------------
	always @(posedge clk) begin : check_outputs
		data_t want;
		if (rstn) begin
			if (neigh_data_out_v) begin
				if (neigh_full_in) begin
					proto_errs++;
					$display("neighbor output written while downstream full at %0t", $time);
				end
				if (expect_q.size() == 0) begin
					proto_errs++;
					$display("unexpected neighbor output %h at %0t", neigh_data_out, $time);
				end else begin
					want = expect_q.pop_front();
					if (neigh_data_out !== want) begin
						value_errs++;
						$display("** Error neigh_data_out expected %h got %h at %0t",
							want, neigh_data_out, $time);
					end
				end
			end
			if (eoi) begin
				eoi_count++;
				if (eoi_count > start_count) begin
					proto_errs++;
					$display("end of program pulse without a start at %0t", $time);
				end
				if (expect_q.size() != 0) begin
					proto_errs++;
					$display("end of program with %0d outputs missing", expect_q.size());
				end
			end
		end
	end

	initial begin : main
		int fd;
		int lines;
		byte cmd;
		logic [31:0] a;
		logic [31:0] b;
		string line;

		clk = 1'b0;
		rstn = 1'b0;
		start = 1'b0;
		prog_wrt = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		mem_wrt = 1'b0;
		mem_addr = '0;
		mem_data = '0;
		neigh_data_in = '0;
		neigh_data_in_v = 1'b0;
		neigh_full_in = 1'b0;
		lines = 0;

		// first pass only sizes the watchdog
		fd = $fopen("pe_trace.txt", "r");
		if (fd != 0) begin
			while ($fgets(line, fd) != 0) begin
				lines++;
			end
			$fclose(fd);
		end
		line_count = lines;

		repeat (16) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;

		fd = $fopen("pe_trace.txt", "r");
		if (fd == 0) begin
			proto_errs++;
			$display("could not open pe_trace.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				cmd = line.getc(0);
				a = '0;
				b = '0;
				if (line.len() > 1) begin
					void'($sscanf(line.substr(1, line.len() - 1), "%h %h", a, b));
				end
				case (cmd)
					"P": load_prog(inst_addr_t'(a), inst_t'(b));
					"M": load_data(mem_addr_t'(a), mem_word_t'(b));
					"N": push_neigh(data_t'(a), b[1:0]);
					"B": hold_full_in(a[0], int'(b));
					"S": pulse_start();
					"E": expect_q.push_back(data_t'(a));
					"D": wait_end();
					"#", "\n", "\r": ;
					default: begin
						proto_errs++;
						$display("unknown trace command in line: %s", line);
					end
				endcase
			end
			$fclose(fd);
		end

		repeat (4) @(negedge clk);
		if (expect_q.size() != 0) begin
			proto_errs++;
			$display("%0d expected outputs never appeared", expect_q.size());
		end
		if (eoi_count != start_count) begin
			proto_errs++;
			$display("%0d starts but %0d end of program pulses", start_count, eoi_count);
		end
		$display("errors: %0d value, %0d protocol", value_errs, proto_errs);
		if (value_errs + proto_errs == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// budget of 40 cycles per trace line
	initial begin : watchdog
		wait (line_count > 0);
		repeat (line_count * 40 + 200) @(posedge clk);
		$display("timeout: trace not finished after %0d cycles", line_count * 40 + 200);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== pe_top.sv ====
`timescale 1ns/100ps

module pe_top import pe_pkg::*; (
	input  logic       clk,
	input  logic       rstn,
	input  logic       start,
	input  logic       prog_wrt,
	input  inst_addr_t prog_addr,
	input  inst_t      prog_data,
	input  logic       mem_wrt,
	input  mem_addr_t  mem_addr,
	input  mem_word_t  mem_data,
	input  data_t      neigh_data_in,
	input  logic       neigh_data_in_v,
	input  logic       neigh_full_in,
	output logic       neigh_full,
	output data_t      neigh_data_out,
	output logic       neigh_data_out_v,
	output logic       pe_stall,
	output logic       eoi
);

	inst_t inst;
	logic pc_clear;
	logic pc_step;
	logic fetch;
	mem_addr_t mem_rd_addr;
	mem_word_t mem_rd;
	interim_addr_t interim_rd_addr0;
	interim_addr_t interim_rd_addr1;
	data_t interim_rd0;
	data_t interim_rd1;
	logic interim_wrt;
	interim_addr_t interim_wrt_addr;
	logic neigh_pop;
	logic neigh_empty;
	data_t neigh_rd;
	logic exec;
	fn_t fn;
	ns_t src0_ns;
	ns_t src1_ns;
	data_t result;

	//----------------------------------------
	// storage
	//----------------------------------------
	instruction_memory u_imem (
		.clk(clk), .rstn(rstn),
		.prog_wrt(prog_wrt), .prog_addr(prog_addr), .prog_data(prog_data),
		.pc_clear(pc_clear), .pc_step(pc_step), .fetch(fetch), .inst(inst)
	);

	data_memory u_dmem (
		.clk(clk), .mem_wrt(mem_wrt), .mem_addr(mem_addr), .mem_data(mem_data),
		.rd_addr(mem_rd_addr), .rd_data(mem_rd)
	);

	// result feeds both the scratch write and the neighbor output
	interim_buffer u_interim (
		.clk(clk), .rstn(rstn),
		.wrt_en(interim_wrt), .wrt_addr(interim_wrt_addr), .wrt_data(result),
		.rd_addr0(interim_rd_addr0), .rd_addr1(interim_rd_addr1),
		.rd_data0(interim_rd0), .rd_data1(interim_rd1)
	);

	neigh_fifo u_neigh_fifo (
		.clk(clk), .rstn(rstn),
		.data_in(neigh_data_in), .data_in_valid(neigh_data_in_v),
		.pop(neigh_pop), .data_out(neigh_rd), .empty(neigh_empty), .full(neigh_full)
	);

	//----------------------------------------
	// datapath and sequencer
	//----------------------------------------
	pe_compute u_compute (
		.clk(clk), .rstn(rstn), .exec(exec), .fn(fn),
		.src0_ns(src0_ns), .src1_ns(src1_ns), .mem_rd(mem_rd),
		.interim_rd0(interim_rd0), .interim_rd1(interim_rd1),
		.neigh_rd(neigh_rd), .result(result)
	);

	pe_control u_control (
		.clk(clk), .rstn(rstn), .start(start), .inst(inst),
		.neigh_empty(neigh_empty), .neigh_full_in(neigh_full_in),
		.pc_clear(pc_clear), .pc_step(pc_step), .fetch(fetch),
		.mem_rd_addr(mem_rd_addr),
		.interim_rd_addr0(interim_rd_addr0), .interim_rd_addr1(interim_rd_addr1),
		.interim_wrt(interim_wrt), .interim_wrt_addr(interim_wrt_addr),
		.neigh_pop(neigh_pop), .exec(exec), .fn(fn),
		.src0_ns(src0_ns), .src1_ns(src1_ns),
		.neigh_data_out_v(neigh_data_out_v), .pe_stall(pe_stall), .eoi(eoi)
	);

	assign neigh_data_out = result;

endmodule

// ==== pe_control.sv ====
`timescale 1ns/100ps
`include "pe_cfg.svh"

module pe_control import pe_pkg::*; (
	input  logic          clk,
	input  logic          rstn,
	input  logic          start,
	input  inst_t         inst,
	input  logic          neigh_empty,
	input  logic          neigh_full_in,
	output logic          pc_clear,
	output logic          pc_step,
	output logic          fetch,
	output mem_addr_t     mem_rd_addr,
	output interim_addr_t interim_rd_addr0,
	output interim_addr_t interim_rd_addr1,
	output logic          interim_wrt,
	output interim_addr_t interim_wrt_addr,
	output logic          neigh_pop,
	output logic          exec,
	output fn_t           fn,
	output ns_t           src0_ns,
	output ns_t           src1_ns,
	output logic          neigh_data_out_v,
	output logic          pe_stall,
	output logic          eoi
);

	pe_state_e state;
	pe_state_e state_nxt;
	src_idx_t src0_idx;
	src_idx_t src1_idx;
	logic iwrt_flag;
	logic nwrt_flag;
	logic is_end;
	logic neigh_need;
	logic in_wait;
	logic out_wait;
	logic write_go;

	//----------------------------------------
	// instruction fields
	//----------------------------------------
	assign fn = fn_t'(inst[`INST_FN_LSB +: `PE_FN_W]);
	assign src0_ns = ns_t'(inst[`INST_S0NS_LSB +: `PE_NS_W]);
	assign src0_idx = src_idx_t'(inst[`INST_S0IDX_LSB +: `PE_IDX_W]);
	assign src1_ns = ns_t'(inst[`INST_S1NS_LSB +: `PE_NS_W]);
	assign src1_idx = src_idx_t'(inst[`INST_S1IDX_LSB +: `PE_IDX_W]);
	assign iwrt_flag = inst[`INST_IWRT_BIT];
	assign interim_wrt_addr = interim_addr_t'(inst[`INST_IIDX_LSB +: `PE_INTERIM_AW]);
	assign nwrt_flag = inst[`INST_NWRT_BIT];

	// one data memory port, src0 wins
	assign mem_rd_addr = (src0_ns == `NS_DATA) ? mem_addr_t'(src0_idx) : mem_addr_t'(src1_idx);
	assign interim_rd_addr0 = src0_idx[`PE_INTERIM_AW-1:0];
	assign interim_rd_addr1 = src1_idx[`PE_INTERIM_AW-1:0];

	assign is_end = (fn == `FN_END);
	assign neigh_need = (src0_ns == `NS_NEIGH) || (src1_ns == `NS_NEIGH);

	// waits: starved neighbor input, blocked neighbor output
	assign in_wait = (state == OPERAND) && !is_end && neigh_need && neigh_empty;
	assign out_wait = (state == WRITE) && nwrt_flag && neigh_full_in;
	assign write_go = (state == WRITE) && !out_wait;

	assign pc_clear = (state == IDLE) && start;
	assign fetch = (state == FETCH);
	assign neigh_pop = (state == OPERAND) && !is_end && neigh_need && !neigh_empty;
	assign exec = (state == EXECUTE);
	assign pc_step = write_go;
	assign interim_wrt = write_go && iwrt_flag;
	assign neigh_data_out_v = write_go && nwrt_flag;
	assign pe_stall = in_wait || out_wait;
	assign eoi = (state == OPERAND) && is_end;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:    if (start) state_nxt = FETCH;
			FETCH:   state_nxt = OPERAND;
			OPERAND: begin
				if (is_end) begin
					state_nxt = IDLE;
				end else if (!in_wait) begin
					state_nxt = EXECUTE;
				end
			end
			EXECUTE: state_nxt = WRITE;
			WRITE:   if (write_go) state_nxt = FETCH;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// program may only hold defined function codes
	fn_code_chk: assert property (@(posedge clk) disable iff (!rstn)
		(state == OPERAND) |-> (fn <= `FN_PASS));

endmodule

// ==== pe_compute.sv ====
`timescale 1ns/100ps
`include "pe_cfg.svh"

module pe_compute import pe_pkg::*; (
	input  logic      clk,
	input  logic      rstn,
	input  logic      exec,
	input  fn_t       fn,
	input  ns_t       src0_ns,
	input  ns_t       src1_ns,
	input  mem_word_t mem_rd,
	input  data_t     interim_rd0,
	input  data_t     interim_rd1,
	input  data_t     neigh_rd,
	output data_t     result
);

	data_t mem_sext;
	data_t neigh_q;
	data_t op0;
	data_t op1;
	data_t alu_out;

	// namespace mux, shared by both operands
	function automatic data_t op_sel(ns_t ns, data_t mem_w, data_t interim_w,
		data_t neigh_w, data_t res_w);
		case (ns)
			`NS_DATA:    op_sel = mem_w;
			`NS_INTERIM: op_sel = interim_w;
			`NS_NEIGH:   op_sel = neigh_w;
			default:     op_sel = res_w;
		endcase
	endfunction

	// neighbor head sampled in the pop cycle, lines up with the memory reads
	always_ff @(posedge clk) begin
		neigh_q <= neigh_rd;
	end

	assign mem_sext = {{(`PE_DATA_W - `PE_MEM_W){mem_rd[`PE_MEM_W-1]}}, mem_rd};
	assign op0 = op_sel(src0_ns, mem_sext, interim_rd0, neigh_q, result);
	assign op1 = op_sel(src1_ns, mem_sext, interim_rd1, neigh_q, result);

	//----------------------------------------
	// alu
	//----------------------------------------
	always_comb begin
		case (fn)
			`FN_ADD:  alu_out = op0 + op1;
			`FN_SUB:  alu_out = op0 - op1;
			`FN_MUL:  alu_out = data_t'($signed(op0) * $signed(op1));
			`FN_MAX:  alu_out = ($signed(op0) > $signed(op1)) ? op0 : op1;
			`FN_PASS: alu_out = op0;
			default:  alu_out = result;
		endcase
	end

	// result survives between instructions for NS_RESULT
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			result <= '0;
		end else if (exec) begin
			result <= alu_out;
		end
	end

endmodule

// ==== neigh_fifo.sv ====
`timescale 1ns/100ps
`include "pe_cfg.svh"

module neigh_fifo import pe_pkg::*; (
	input  logic  clk,
	input  logic  rstn,
	input  data_t data_in,
	input  logic  data_in_valid,
	input  logic  pop,
	output data_t data_out,
	output logic  empty,
	output logic  full
);

	data_t buf_mem [`PE_NEIGH_DEPTH];
	logic [`PE_NEIGH_PTR_W-1:0] wr_ptr;
	logic [`PE_NEIGH_PTR_W-1:0] rd_ptr;
	logic [`PE_NEIGH_PTR_W:0] count;
	logic push_ok;
	logic pop_ok;

	assign push_ok = data_in_valid && !full;
	assign pop_ok = pop && !empty;

	always_ff @(posedge clk) begin
		if (push_ok) begin
			buf_mem[wr_ptr] <= data_in;
		end
	end

	// pointers wrap on their own at depth 4
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + push_ok - pop_ok;
		end
	end

	assign data_out = buf_mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == `PE_NEIGH_DEPTH);

	//----------------------------------------
	// neighbor protocol checks
	//----------------------------------------
	no_pop_empty: assert property (@(posedge clk) disable iff (!rstn) pop |-> !empty);
	no_push_full: assert property (@(posedge clk) disable iff (!rstn) data_in_valid |-> !full);

endmodule

// ==== interim_buffer.sv ====
`timescale 1ns/100ps
`include "pe_cfg.svh"

module interim_buffer import pe_pkg::*; (
	input  logic          clk,
	input  logic          rstn,
	input  logic          wrt_en,
	input  interim_addr_t wrt_addr,
	input  data_t         wrt_data,
	input  interim_addr_t rd_addr0,
	input  interim_addr_t rd_addr1,
	output data_t         rd_data0,
	output data_t         rd_data1
);

	data_t regs [1 << `PE_INTERIM_AW];

	// scratch words start at zero
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			for (int i = 0; i < (1 << `PE_INTERIM_AW); i++) begin
				regs[i] <= '0;
			end
		end else if (wrt_en) begin
			regs[wrt_addr] <= wrt_data;
		end
	end

	// one read port per source operand
	always_ff @(posedge clk) begin
		rd_data0 <= regs[rd_addr0];
		rd_data1 <= regs[rd_addr1];
	end

endmodule

// ==== data_memory.sv ====
`timescale 1ns/100ps
`include "pe_cfg.svh"

module data_memory import pe_pkg::*; (
	input  logic      clk,
	input  logic      mem_wrt,
	input  mem_addr_t mem_addr,
	input  mem_word_t mem_data,
	input  mem_addr_t rd_addr,
	output mem_word_t rd_data
);

	mem_word_t mem [1 << `PE_MEM_AW];

	//----------------------------------------
	// host write port
	//----------------------------------------
	always_ff @(posedge clk) begin
		if (mem_wrt) begin
			mem[mem_addr] <= mem_data;
		end
	end

	// operand read, registered every cycle
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== instruction_memory.sv ====
`timescale 1ns/100ps
`include "pe_cfg.svh"

module instruction_memory import pe_pkg::*; (
	input  logic       clk,
	input  logic       rstn,
	input  logic       prog_wrt,
	input  inst_addr_t prog_addr,
	input  inst_t      prog_data,
	input  logic       pc_clear,
	input  logic       pc_step,
	input  logic       fetch,
	output inst_t      inst
);

	inst_t mem [1 << `PE_INST_AW];
	inst_addr_t pc;

	// host program load
	always_ff @(posedge clk) begin
		if (prog_wrt) begin
			mem[prog_addr] <= prog_data;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			pc <= '0;
		end else if (pc_clear) begin
			pc <= '0;
		end else if (pc_step) begin
			pc <= pc + 1'b1;
		end
	end

	// word is valid at the end of the fetch cycle
	always_ff @(posedge clk) begin
		if (fetch) begin
			inst <= mem[pc];
		end
	end

	// program must end before running off the top
	pc_wrap_chk: assert property (@(posedge clk) disable iff (!rstn)
		pc_step |-> pc != {`PE_INST_AW{1'b1}});

endmodule

// ==== pe_pkg.sv ====
`include "pe_cfg.svh"

package pe_pkg;

	// datapath and memory words
	typedef logic [`PE_DATA_W-1:0] data_t;
	typedef logic [`PE_MEM_W-1:0] mem_word_t;
	typedef logic [`PE_INST_W-1:0] inst_t;

	// instruction fields
	typedef logic [`PE_FN_W-1:0] fn_t;
	typedef logic [`PE_NS_W-1:0] ns_t;
	typedef logic [`PE_IDX_W-1:0] src_idx_t;

	// addresses
	typedef logic [`PE_INTERIM_AW-1:0] interim_addr_t;
	typedef logic [`PE_MEM_AW-1:0] mem_addr_t;
	typedef logic [`PE_INST_AW-1:0] inst_addr_t;

	// sequencer, one instruction in flight
	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		OPERAND,
		EXECUTE,
		WRITE
	} pe_state_e;

endpackage

// ==== pe_cfg.svh ====
`ifndef PE_CFG_SVH
`define PE_CFG_SVH

// datapath and storage sizes
`define PE_DATA_W       32
`define PE_MEM_W        16
`define PE_FN_W         3
`define PE_NS_W         2
`define PE_IDX_W        4
`define PE_INTERIM_AW   3
`define PE_MEM_AW       4
`define PE_INST_AW      5
`define PE_INST_W       20
`define PE_NEIGH_DEPTH  4
`define PE_NEIGH_PTR_W  2

// function codes
`define FN_END   3'd0
`define FN_ADD   3'd1
`define FN_SUB   3'd2
`define FN_MUL   3'd3
`define FN_MAX   3'd4
`define FN_PASS  3'd5

// source namespaces
`define NS_DATA     2'd0
`define NS_INTERIM  2'd1
`define NS_NEIGH    2'd2
`define NS_RESULT   2'd3

//----------------------------------------
// instruction layout, msb first
// fn | src0 ns | src0 idx | src1 ns | src1 idx | iwrt | iidx | nwrt
//----------------------------------------
`define INST_FN_LSB     17
`define INST_S0NS_LSB   15
`define INST_S0IDX_LSB  11
`define INST_S1NS_LSB   9
`define INST_S1IDX_LSB  5
`define INST_IWRT_BIT   4
`define INST_IIDX_LSB   1
`define INST_NWRT_BIT   0

`endif
